//--- common/radio_pkg.sv
`default_nettype none

package radio_pkg;

  // ************************************************************
  // widths and value types

  localparam int N_CHAN = 4;
  localparam int UP_TIMEOUT = 16;

  typedef logic [13:0] up_addr_t;
  typedef logic [31:0] up_data_t;
  typedef logic [15:0] axi_addr_t;
  typedef logic [11:0] raw_sample_t;
  typedef logic [15:0] sample_t;
  typedef logic [15:0] tdd_count_t;
  typedef logic [5:0]  blk_sel_t;
  typedef logic [7:0]  reg_off_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [$clog2(UP_TIMEOUT+1)-1:0] tmo_count_t;

  // ************************************************************
  // address map, block select is word address 13:8

  localparam blk_sel_t RX_BASE  = 6'd0;
  localparam blk_sel_t TX_BASE  = 6'd1;
  localparam blk_sel_t TDD_BASE = 6'd2;

  localparam reg_off_t REG_VERSION    = 8'd0;
  localparam reg_off_t REG_SCRATCH    = 8'd1;
  localparam reg_off_t REG_RX_CTRL    = 8'd2;
  localparam reg_off_t REG_RX_STAT    = 8'd3;
  localparam reg_off_t REG_TX_CTRL    = 8'd0;
  localparam reg_off_t REG_TX_STAT    = 8'd1;
  localparam reg_off_t REG_TDD_CTRL   = 8'd0;
  localparam reg_off_t REG_TDD_FRAME  = 8'd1;
  localparam reg_off_t REG_TDD_RX_WIN = 8'd2;
  localparam reg_off_t REG_TDD_TX_WIN = 8'd3;

  localparam up_data_t  RADIO_VERSION = 32'h0001_0061;
  localparam axi_resp_t RESP_OKAY     = 2'b00;
  localparam axi_resp_t RESP_SLVERR   = 2'b10;

  // ************************************************************
  // bus structs

  typedef struct packed {
    logic      awvalid;
    axi_addr_t awaddr;
    logic      wvalid;
    up_data_t  wdata;
    logic      bready;
    logic      arvalid;
    axi_addr_t araddr;
    logic      rready;
  } axi_lite_req_t;

  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    axi_resp_t bresp;
    logic      arready;
    logic      rvalid;
    axi_resp_t rresp;
    up_data_t  rdata;
  } axi_lite_rsp_t;

  typedef struct packed {
    logic     wreq;
    up_addr_t waddr;
    up_data_t wdata;
    logic     rreq;
    up_addr_t raddr;
  } up_req_t;

  typedef struct packed {
    logic     wack;
    logic     rack;
    up_data_t rdata;
  } up_rsp_t;

  // ************************************************************
  // sample streams, index 0 is I0, then Q0, I1, Q1

  typedef struct packed {
    logic                         valid;
    raw_sample_t [N_CHAN-1:0]     data;
  } adc_raw_t;

  typedef struct packed {
    logic [N_CHAN-1:0]    enable;
    logic [N_CHAN-1:0]    valid;
    sample_t [N_CHAN-1:0] data;
  } adc_out_t;

  typedef struct packed {
    sample_t [N_CHAN-1:0] data;
  } dac_in_t;

  typedef struct packed {
    logic [N_CHAN-1:0] enable;
    logic [N_CHAN-1:0] valid;
  } dac_out_t;

  typedef struct packed {
    logic                     valid;
    raw_sample_t [N_CHAN-1:0] data;
  } dev_tx_t;

  typedef struct packed {
    logic rx_gate;
    logic tx_gate;
  } tdd_gate_t;

  // window register layout, end in the upper half
  typedef struct packed {
    tdd_count_t win_end;
    tdd_count_t win_start;
  } tdd_win_t;

  typedef enum logic [2:0] {IDLE, WRITE, READ, BRESP, RRESP} axi_state_e;

endpackage

`default_nettype wire

//--- hdl/up_axi_lite.sv
`timescale 1ns/1ns
`default_nettype none

module up_axi_lite (
  input  logic                     clk,
  input  logic                     up_rstn,
  input  radio_pkg::axi_lite_req_t axi_req,
  output radio_pkg::axi_lite_rsp_t axi_rsp,
  output radio_pkg::up_req_t       up_req,
  input  radio_pkg::up_rsp_t       up_rsp
);

  import radio_pkg::*;

  axi_state_e state;
  tmo_count_t tmo_cnt;
  logic       tmo_done;

  // nobody answered this address
  assign tmo_done = (tmo_cnt == tmo_count_t'(UP_TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      state <= IDLE;
      tmo_cnt <= '0;
      axi_rsp <= '0;
      up_req.wreq <= 1'b0;
      up_req.rreq <= 1'b0;
    end else begin
      // ready and request strobes are single cycle
      axi_rsp.awready <= 1'b0;
      axi_rsp.wready <= 1'b0;
      axi_rsp.arready <= 1'b0;
      up_req.wreq <= 1'b0;
      up_req.rreq <= 1'b0;
      case (state)
        IDLE: begin
          tmo_cnt <= '0;
          if (axi_req.awvalid && axi_req.wvalid) begin
            axi_rsp.awready <= 1'b1;
            axi_rsp.wready <= 1'b1;
            up_req.wreq <= 1'b1;
            up_req.waddr <= axi_req.awaddr[15:2];
            up_req.wdata <= axi_req.wdata;
            state <= WRITE;
          end else if (axi_req.arvalid) begin
            axi_rsp.arready <= 1'b1;
            up_req.rreq <= 1'b1;
            up_req.raddr <= axi_req.araddr[15:2];
            state <= READ;
          end
        end
        WRITE: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (up_rsp.wack || tmo_done) begin
            axi_rsp.bvalid <= 1'b1;
            axi_rsp.bresp <= up_rsp.wack ? RESP_OKAY : RESP_SLVERR;
            state <= BRESP;
          end
        end
        READ: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (up_rsp.rack || tmo_done) begin
            axi_rsp.rvalid <= 1'b1;
            axi_rsp.rresp <= up_rsp.rack ? RESP_OKAY : RESP_SLVERR;
            axi_rsp.rdata <= up_rsp.rack ? up_rsp.rdata : '0;
            state <= RRESP;
          end
        end
        BRESP: begin
          if (axi_req.bready) begin
            axi_rsp.bvalid <= 1'b0;
            state <= IDLE;
          end
        end
        RRESP: begin
          if (axi_req.rready) begin
            axi_rsp.rvalid <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // responses wait for the master
  bvalid_hold: assert property (@(posedge clk) disable iff (!up_rstn)
    axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid);

  rvalid_hold: assert property (@(posedge clk) disable iff (!up_rstn)
    axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata));

endmodule

`default_nettype wire

//--- rx/radio_rx.sv
`timescale 1ns/1ns
`default_nettype none

module radio_rx (
  input  logic                clk,
  input  logic                up_rstn,
  input  radio_pkg::up_req_t  up_req,
  output radio_pkg::up_rsp_t  up_rsp,
  input  radio_pkg::adc_raw_t adc_raw,
  input  logic                rx_gate,
  input  logic                adc_dovf,
  output radio_pkg::adc_out_t adc_out
);

  import radio_pkg::*;

  up_data_t             scratch;
  logic [N_CHAN-1:0]    rx_enable;
  logic                 fmt_signed;
  logic                 ovf;
  logic                 wsel;
  logic                 rsel;
  up_data_t             rd_data;
  logic [N_CHAN-1:0]    adc_valid;
  sample_t [N_CHAN-1:0] adc_data;

  // ************************************************************
  // register bus

  assign wsel = up_req.wreq && (up_req.waddr[13:8] == RX_BASE);
  assign rsel = up_req.rreq && (up_req.raddr[13:8] == RX_BASE);

  always_comb begin
    case (up_req.raddr[7:0])
      REG_VERSION: rd_data = RADIO_VERSION;
      REG_SCRATCH: rd_data = scratch;
      REG_RX_CTRL: rd_data = {27'd0, fmt_signed, rx_enable};
      REG_RX_STAT: rd_data = {31'd0, ovf};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      up_rsp <= '0;
      scratch <= '0;
      rx_enable <= '0;
      fmt_signed <= 1'b0;
      ovf <= 1'b0;
    end else begin
      up_rsp.wack <= wsel;
      up_rsp.rack <= rsel;
      up_rsp.rdata <= rsel ? rd_data : '0;
      if (wsel) begin
        case (up_req.waddr[7:0])
          REG_SCRATCH: scratch <= up_req.wdata;
          REG_RX_CTRL: begin
            rx_enable <= up_req.wdata[N_CHAN-1:0];
            fmt_signed <= up_req.wdata[4];
          end
          REG_RX_STAT: if (up_req.wdata[0]) ovf <= 1'b0;
          default: ;
        endcase
      end
      // a new overflow beats a clear in the same cycle
      if (adc_dovf) ovf <= 1'b1;
    end
  end

  // ************************************************************
  // sample path, one register stage

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      adc_valid <= '0;
    end else begin
      adc_valid <= {N_CHAN{adc_raw.valid & rx_gate}} & rx_enable;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_CHAN; i++) begin
      if (fmt_signed) begin
        adc_data[i] <= {{4{adc_raw.data[i][11]}}, adc_raw.data[i]};
      end else begin
        adc_data[i] <= {4'd0, adc_raw.data[i]};
      end
    end
  end

  assign adc_out = '{enable: rx_enable, valid: adc_valid, data: adc_data};

  // valid follows the enable of the sampling cycle
  valid_en: assert property (@(posedge clk) disable iff (!up_rstn)
    (adc_valid & ~$past(rx_enable)) == '0);

endmodule

`default_nettype wire

//--- tx/radio_tx.sv
`timescale 1ns/1ns
`default_nettype none

module radio_tx (
  input  logic               clk,
  input  logic               up_rstn,
  input  radio_pkg::up_req_t up_req,
  output radio_pkg::up_rsp_t up_rsp,
  input  logic               dev_tx_req,
  input  logic               tx_gate,
  input  radio_pkg::dac_in_t dac_in,
  input  logic               dac_dunf,
  output radio_pkg::dac_out_t dac_out,
  output radio_pkg::dev_tx_t dev_tx
);

  import radio_pkg::*;

  logic [N_CHAN-1:0]        tx_enable;
  logic                     unf;
  logic                     wsel;
  logic                     rsel;
  up_data_t                 rd_data;
  logic [N_CHAN-1:0]        dac_valid;
  logic                     dev_valid;
  raw_sample_t [N_CHAN-1:0] dev_data;

  // ************************************************************
  // register bus

  assign wsel = up_req.wreq && (up_req.waddr[13:8] == TX_BASE);
  assign rsel = up_req.rreq && (up_req.raddr[13:8] == TX_BASE);

  always_comb begin
    case (up_req.raddr[7:0])
      REG_TX_CTRL: rd_data = {28'd0, tx_enable};
      REG_TX_STAT: rd_data = {31'd0, unf};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      up_rsp <= '0;
      tx_enable <= '0;
      unf <= 1'b0;
    end else begin
      up_rsp.wack <= wsel;
      up_rsp.rack <= rsel;
      up_rsp.rdata <= rsel ? rd_data : '0;
      if (wsel && (up_req.waddr[7:0] == REG_TX_CTRL)) begin
        tx_enable <= up_req.wdata[N_CHAN-1:0];
      end
      if (wsel && (up_req.waddr[7:0] == REG_TX_STAT) && up_req.wdata[0]) begin
        unf <= 1'b0;
      end
      if (dac_dunf) unf <= 1'b1;
    end
  end

  // ************************************************************
  // dma requests, then the device word a cycle later

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      dac_valid <= '0;
      dev_valid <= 1'b0;
    end else begin
      dac_valid <= {N_CHAN{dev_tx_req & tx_gate}} & tx_enable;
      dev_valid <= |dac_valid;
    end
  end

  // keep the upper 12 bits, idle channels send zero
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_CHAN; i++) begin
      dev_data[i] <= dac_valid[i] ? dac_in.data[i][15:4] : '0;
    end
  end

  assign dac_out = '{enable: tx_enable, valid: dac_valid};
  assign dev_tx = '{valid: dev_valid, data: dev_data};

endmodule

`default_nettype wire

//--- tdd/tdd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tdd_ctrl (
  input  logic                 clk,
  input  logic                 up_rstn,
  input  radio_pkg::up_req_t   up_req,
  output radio_pkg::up_rsp_t   up_rsp,
  input  logic                 up_enable,
  input  logic                 up_txnrx,
  output radio_pkg::tdd_gate_t tdd_gate,
  output logic                 enable,
  output logic                 txnrx
);

  import radio_pkg::*;

  logic       tdd_on;
  tdd_count_t frame_len;
  tdd_win_t   rx_win;
  tdd_win_t   tx_win;
  tdd_count_t cnt;
  logic       wsel;
  logic       rsel;
  up_data_t   rd_data;
  logic       rx_open;
  logic       tx_open;

  // start is inclusive, end is not
  function automatic logic in_window(tdd_count_t count, tdd_win_t win);
    return (count >= win.win_start) && (count < win.win_end);
  endfunction

  // ************************************************************
  // register bus

  assign wsel = up_req.wreq && (up_req.waddr[13:8] == TDD_BASE);
  assign rsel = up_req.rreq && (up_req.raddr[13:8] == TDD_BASE);

  always_comb begin
    case (up_req.raddr[7:0])
      REG_TDD_CTRL:   rd_data = {31'd0, tdd_on};
      REG_TDD_FRAME:  rd_data = {16'd0, frame_len};
      REG_TDD_RX_WIN: rd_data = rx_win;
      REG_TDD_TX_WIN: rd_data = tx_win;
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      up_rsp <= '0;
      tdd_on <= 1'b0;
      frame_len <= '0;
      rx_win <= '0;
      tx_win <= '0;
    end else begin
      up_rsp.wack <= wsel;
      up_rsp.rack <= rsel;
      up_rsp.rdata <= rsel ? rd_data : '0;
      if (wsel) begin
        case (up_req.waddr[7:0])
          REG_TDD_CTRL:   tdd_on <= up_req.wdata[0];
          REG_TDD_FRAME:  frame_len <= up_req.wdata[15:0];
          REG_TDD_RX_WIN: rx_win <= tdd_win_t'(up_req.wdata);
          REG_TDD_TX_WIN: tx_win <= tdd_win_t'(up_req.wdata);
          default: ;
        endcase
      end
    end
  end

  // ************************************************************
  // frame counter, 0 up to frame_len then wrap

  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      cnt <= '0;
    end else if (!tdd_on || (cnt >= frame_len)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // gates open wide when tdd is off
  assign rx_open = !tdd_on || in_window(cnt, rx_win);
  assign tx_open = !tdd_on || in_window(cnt, tx_win);

  assign tdd_gate = '{rx_gate: rx_open, tx_gate: tx_open};
  assign enable = tdd_on ? (rx_open | tx_open) : up_enable;
  assign txnrx = tdd_on ? tx_open : up_txnrx;

  // a shorter frame takes effect one cycle after the write
  cnt_in_frame: assert property (@(posedge clk) disable iff (!up_rstn)
    tdd_on && $stable(frame_len) |-> cnt <= frame_len);

endmodule

`default_nettype wire

//--- hdl/radio_top.sv
`timescale 1ns/1ns
`default_nettype none

module radio_top (
  input  logic                     clk,
  input  logic                     up_rstn,
  input  radio_pkg::axi_lite_req_t axi_req,
  output radio_pkg::axi_lite_rsp_t axi_rsp,
  input  radio_pkg::adc_raw_t      adc_raw,
  output radio_pkg::adc_out_t      adc_out,
  input  logic                     adc_dovf,
  input  logic                     dev_tx_req,
  input  radio_pkg::dac_in_t       dac_in,
  output radio_pkg::dac_out_t      dac_out,
  input  logic                     dac_dunf,
  output radio_pkg::dev_tx_t       dev_tx,
  input  logic                     up_enable,
  input  logic                     up_txnrx,
  output logic                     enable,
  output logic                     txnrx
);

  import radio_pkg::*;

  up_req_t   up_req;
  up_rsp_t   up_rsp;
  up_rsp_t   rx_rsp;
  up_rsp_t   tx_rsp;
  up_rsp_t   tdd_rsp;
  tdd_gate_t tdd_gate;

  // idle blocks return zero, so an OR merges the answers
  always_ff @(posedge clk) begin
    if (!up_rstn) begin
      up_rsp <= '0;
    end else begin
      up_rsp.wack <= rx_rsp.wack | tx_rsp.wack | tdd_rsp.wack;
      up_rsp.rack <= rx_rsp.rack | tx_rsp.rack | tdd_rsp.rack;
      up_rsp.rdata <= rx_rsp.rdata | tx_rsp.rdata | tdd_rsp.rdata;
    end
  end

  up_axi_lite i_axi (
    .clk     (clk),
    .up_rstn (up_rstn),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp),
    .up_req  (up_req),
    .up_rsp  (up_rsp));

  radio_rx i_rx (
    .clk      (clk),
    .up_rstn  (up_rstn),
    .up_req   (up_req),
    .up_rsp   (rx_rsp),
    .adc_raw  (adc_raw),
    .rx_gate  (tdd_gate.rx_gate),
    .adc_dovf (adc_dovf),
    .adc_out  (adc_out));

  radio_tx i_tx (
    .clk        (clk),
    .up_rstn    (up_rstn),
    .up_req     (up_req),
    .up_rsp     (tx_rsp),
    .dev_tx_req (dev_tx_req),
    .tx_gate    (tdd_gate.tx_gate),
    .dac_in     (dac_in),
    .dac_dunf   (dac_dunf),
    .dac_out    (dac_out),
    .dev_tx     (dev_tx));

  tdd_ctrl i_tdd (
    .clk       (clk),
    .up_rstn   (up_rstn),
    .up_req    (up_req),
    .up_rsp    (tdd_rsp),
    .up_enable (up_enable),
    .up_txnrx  (up_txnrx),
    .tdd_gate  (tdd_gate),
    .enable    (enable),
    .txnrx     (txnrx));

endmodule

`default_nettype wire

//--- bench/radio_tb.sv
`timescale 1ns/1ns
`default_nettype none

module radio_tb;

  import radio_pkg::*;

  localparam int          WAIT_CYCLES = 4 * UP_TIMEOUT;
  localparam logic [31:0] LFSR_SEED   = 32'd81996;

  logic          clk;
  logic          up_rstn;
  axi_lite_req_t axi_req;
  axi_lite_rsp_t axi_rsp;
  adc_raw_t      adc_raw;
  adc_out_t      adc_out;
  logic          adc_dovf;
  logic          dev_tx_req;
  dac_in_t       dac_in;
  dac_out_t      dac_out;
  logic          dac_dunf;
  dev_tx_t       dev_tx;
  logic          up_enable;
  logic          up_txnrx;
  logic          enable;
  logic          txnrx;

  // register shadows of the model
  logic [31:0]       lfsr;
  logic [N_CHAN-1:0] rx_en_sh;
  logic              rx_fmt_sh;
  logic [N_CHAN-1:0] tx_en_sh;
  int                value_errors;
  int                timeout_errors;

  radio_top dut (
    .clk        (clk),
    .up_rstn    (up_rstn),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp),
    .adc_raw    (adc_raw),
    .adc_out    (adc_out),
    .adc_dovf   (adc_dovf),
    .dev_tx_req (dev_tx_req),
    .dac_in     (dac_in),
    .dac_out    (dac_out),
    .dac_dunf   (dac_dunf),
    .dev_tx     (dev_tx),
    .up_enable  (up_enable),
    .up_txnrx   (up_txnrx),
    .enable     (enable),
    .txnrx      (txnrx));

  always #20 clk = ~clk;

  // ************************************************************
  // 32-bit fibonacci lfsr with taps 32 22 2 1 for random bits

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic up_addr_t reg_addr(input blk_sel_t blk, input reg_off_t off);
    return {blk, off};
  endfunction

  // ************************************************************
  // compare tasks

  task automatic note_timeout(input string what);
    timeout_errors++;
    $display("timeout: no %s within %0d cycles", what, WAIT_CYCLES);
  endtask

  task automatic check_data(input string name, input up_data_t got, input up_data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_adc(input adc_out_t got, input adc_out_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL adc_out got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_dac(input dac_out_t got, input dac_out_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL dac_out got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_dev(input dev_tx_t got, input dev_tx_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL dev_tx got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ************************************************************
  // axi4-lite master driving on the rising edge and sampling on the falling

  task automatic axi_write(input up_addr_t addr, input up_data_t data, output axi_resp_t resp);
    int t;
    @(posedge clk);
    axi_req.awvalid <= 1'b1;
    axi_req.awaddr <= {addr, 2'b00};
    axi_req.wvalid <= 1'b1;
    axi_req.wdata <= data;
    t = 0;
    @(negedge clk);
    while (!(axi_rsp.awready && axi_rsp.wready) && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    if (!(axi_rsp.awready && axi_rsp.wready)) note_timeout("awready and wready");
    @(posedge clk);
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid <= 1'b0;
    t = 0;
    @(negedge clk);
    while (!axi_rsp.bvalid && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    if (!axi_rsp.bvalid) note_timeout("bvalid");
    resp = axi_rsp.bresp;
    @(posedge clk);
    axi_req.bready <= 1'b1;
    @(posedge clk);
    axi_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input up_addr_t addr, output up_data_t data, output axi_resp_t resp);
    int t;
    @(posedge clk);
    axi_req.arvalid <= 1'b1;
    axi_req.araddr <= {addr, 2'b00};
    t = 0;
    @(negedge clk);
    while (!axi_rsp.arready && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    if (!axi_rsp.arready) note_timeout("arready");
    @(posedge clk);
    axi_req.arvalid <= 1'b0;
    t = 0;
    @(negedge clk);
    while (!axi_rsp.rvalid && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    if (!axi_rsp.rvalid) note_timeout("rvalid");
    data = axi_rsp.rdata;
    resp = axi_rsp.rresp;
    @(posedge clk);
    axi_req.rready <= 1'b1;
    @(posedge clk);
    axi_req.rready <= 1'b0;
  endtask

  task automatic reg_write(input up_addr_t addr, input up_data_t data);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    check_resp("bresp", resp, RESP_OKAY);
  endtask

  task automatic reg_read(input up_addr_t addr, output up_data_t data);
    axi_resp_t resp;
    axi_read(addr, data, resp);
    check_resp("rresp", resp, RESP_OKAY);
  endtask

  task automatic reg_check(input string name, input up_addr_t addr, input up_data_t exp);
    up_data_t got;
    reg_read(addr, got);
    check_data(name, got, exp);
  endtask

  // ************************************************************
  // sample streams against a model that keeps a one cycle delayed copy of the inputs

  task automatic run_stream(input int cycles, input logic tdd);
    adc_raw_t          prv_raw;
    logic              prv_rx_gate;
    logic              prv_req;
    logic              prv_tx_gate;
    dac_in_t           prv_dac;
    logic [N_CHAN-1:0] prv_dac_valid;
    adc_out_t          exp_adc;
    dac_out_t          exp_dac;
    dev_tx_t           exp_dev;
    @(negedge clk);
    prv_raw = adc_raw;
    prv_req = dev_tx_req;
    prv_dac = dac_in;
    prv_dac_valid = '0;
    // the pins tell which gate is open since the windows do not overlap
    prv_rx_gate = tdd ? (enable & ~txnrx) : 1'b1;
    prv_tx_gate = tdd ? txnrx : 1'b1;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      adc_raw.valid <= take_bit();
      dev_tx_req <= take_bit();
      up_enable <= take_bit();
      up_txnrx <= take_bit();
      for (int i = 0; i < N_CHAN; i++) begin
        adc_raw.data[i] <= raw_sample_t'(take_bits(12));
        dac_in.data[i] <= sample_t'(take_bits(16));
      end
      @(negedge clk);
      exp_adc.enable = rx_en_sh;
      exp_dac.enable = tx_en_sh;
      exp_dev.valid = |prv_dac_valid;
      for (int i = 0; i < N_CHAN; i++) begin
        exp_adc.valid[i] = prv_raw.valid && prv_rx_gate && rx_en_sh[i];
        exp_dac.valid[i] = prv_req && prv_tx_gate && tx_en_sh[i];
        if (rx_fmt_sh) begin
          exp_adc.data[i] = sample_t'($signed(prv_raw.data[i]));
        end else begin
          exp_adc.data[i] = sample_t'(prv_raw.data[i]);
        end
        exp_dev.data[i] = prv_dac_valid[i] ? raw_sample_t'(prv_dac.data[i] >> 4) : '0;
      end
      check_adc(adc_out, exp_adc);
      check_dac(dac_out, exp_dac);
      check_dev(dev_tx, exp_dev);
      if (!tdd) begin
        check_pin("enable", enable, up_enable);
        check_pin("txnrx", txnrx, up_txnrx);
      end
      prv_raw = adc_raw;
      prv_req = dev_tx_req;
      prv_dac = dac_in;
      prv_dac_valid = exp_dac.valid;
      prv_rx_gate = tdd ? (enable & ~txnrx) : 1'b1;
      prv_tx_gate = tdd ? txnrx : 1'b1;
    end
    // drain the pipeline before the bus is used again
    @(posedge clk);
    adc_raw.valid <= 1'b0;
    dev_tx_req <= 1'b0;
    @(posedge clk);
    @(posedge clk);
  endtask

  task automatic count_enable(input tdd_count_t frame, output int n);
    n = 0;
    for (int c = 0; c <= int'(frame); c++) begin
      @(negedge clk);
      if (enable) n++;
    end
  endtask

  task automatic check_sticky(input logic is_tx);
    up_addr_t stat;
    string    name;
    if (is_tx) begin
      stat = reg_addr(TX_BASE, REG_TX_STAT);
      name = "tx_stat";
    end else begin
      stat = reg_addr(RX_BASE, REG_RX_STAT);
      name = "rx_stat";
    end
    @(posedge clk);
    if (is_tx) begin
      dac_dunf <= 1'b1;
    end else begin
      adc_dovf <= 1'b1;
    end
    @(posedge clk);
    dac_dunf <= 1'b0;
    adc_dovf <= 1'b0;
    reg_check(name, stat, 32'd1);
    reg_write(stat, 32'd1);
    reg_check(name, stat, 32'd0);
    repeat (8) @(posedge clk);
    reg_check(name, stat, 32'd0);
  endtask

  // ************************************************************
  // test sequence

  initial begin : main
    up_data_t   d;
    up_data_t   exp_cnt;
    axi_resp_t  resp;
    up_addr_t   addr;
    tdd_count_t frame;
    tdd_count_t rx_start;
    tdd_count_t rx_end;
    tdd_count_t tx_start;
    tdd_count_t tx_end;
    int         n;
    clk = 1'b0;
    up_rstn = 1'b0;
    axi_req = '0;
    adc_raw = '0;
    adc_dovf = 1'b0;
    dev_tx_req = 1'b0;
    dac_in = '0;
    dac_dunf = 1'b0;
    up_enable = 1'b0;
    up_txnrx = 1'b0;
    lfsr = LFSR_SEED;
    rx_en_sh = '0;
    rx_fmt_sh = 1'b0;
    tx_en_sh = '0;
    value_errors = 0;
    timeout_errors = 0;
    repeat (4) @(posedge clk);
    up_rstn <= 1'b1;

    // register read back
    reg_check("version", reg_addr(RX_BASE, REG_VERSION), RADIO_VERSION);
    for (int k = 0; k < 6; k++) begin
      d = take_bits(32);
      reg_write(reg_addr(RX_BASE, REG_SCRATCH), d);
      reg_check("scratch", reg_addr(RX_BASE, REG_SCRATCH), d);
    end
    d = {27'd0, 5'(take_bits(5))};
    reg_write(reg_addr(RX_BASE, REG_RX_CTRL), d);
    reg_check("rx_ctrl", reg_addr(RX_BASE, REG_RX_CTRL), d);
    d = {28'd0, 4'(take_bits(4))};
    reg_write(reg_addr(TX_BASE, REG_TX_CTRL), d);
    reg_check("tx_ctrl", reg_addr(TX_BASE, REG_TX_CTRL), d);
    d = {16'd0, 16'(take_bits(16))};
    reg_write(reg_addr(TDD_BASE, REG_TDD_FRAME), d);
    reg_check("tdd_frame", reg_addr(TDD_BASE, REG_TDD_FRAME), d);
    d = take_bits(32);
    reg_write(reg_addr(TDD_BASE, REG_TDD_RX_WIN), d);
    reg_check("tdd_rx_win", reg_addr(TDD_BASE, REG_TDD_RX_WIN), d);
    d = take_bits(32);
    reg_write(reg_addr(TDD_BASE, REG_TDD_TX_WIN), d);
    reg_check("tdd_tx_win", reg_addr(TDD_BASE, REG_TDD_TX_WIN), d);
    reg_write(reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd1);
    reg_check("tdd_ctrl", reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd1);
    reg_write(reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd0);
    reg_check("tdd_ctrl", reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd0);

    // unmapped block selects run into the bridge timeout
    for (int k = 0; k < 4; k++) begin
      addr = reg_addr(blk_sel_t'(3 + take_bits(5)), reg_off_t'(take_bits(8)));
      axi_write(addr, take_bits(32), resp);
      check_resp("bresp", resp, RESP_SLVERR);
      axi_read(addr, d, resp);
      check_resp("rresp", resp, RESP_SLVERR);
      check_data("rdata", d, '0);
    end

    // streams with tdd off in unsigned then signed format
    for (int f = 0; f < 2; f++) begin
      rx_en_sh = N_CHAN'(take_bits(4));
      rx_fmt_sh = (f == 1);
      tx_en_sh = N_CHAN'(take_bits(4));
      reg_write(reg_addr(RX_BASE, REG_RX_CTRL), {27'd0, rx_fmt_sh, rx_en_sh});
      reg_write(reg_addr(TX_BASE, REG_TX_CTRL), {28'd0, tx_en_sh});
      run_stream(200, 1'b0);
    end

    // tdd frame with an rx window followed by a tx window
    rx_en_sh = '1;
    tx_en_sh = '1;
    reg_write(reg_addr(RX_BASE, REG_RX_CTRL), {27'd0, rx_fmt_sh, rx_en_sh});
    reg_write(reg_addr(TX_BASE, REG_TX_CTRL), {28'd0, tx_en_sh});
    frame = 16'd28 + tdd_count_t'(take_bits(4));
    rx_start = tdd_count_t'(take_bits(3));
    rx_end = rx_start + 16'd1 + tdd_count_t'(take_bits(3));
    tx_start = rx_end + tdd_count_t'(take_bits(2));
    tx_end = tx_start + 16'd1 + tdd_count_t'(take_bits(3));
    exp_cnt = up_data_t'(rx_end - rx_start) + up_data_t'(tx_end - tx_start);
    reg_write(reg_addr(TDD_BASE, REG_TDD_FRAME), {16'd0, frame});
    reg_write(reg_addr(TDD_BASE, REG_TDD_RX_WIN), {rx_end, rx_start});
    reg_write(reg_addr(TDD_BASE, REG_TDD_TX_WIN), {tx_end, tx_start});
    reg_write(reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd1);
    run_stream(3 * (int'(frame) + 1), 1'b1);
    count_enable(frame, n);
    check_data("enable_count", up_data_t'(n), exp_cnt);
    reg_write(reg_addr(TDD_BASE, REG_TDD_CTRL), 32'd0);
    run_stream(100, 1'b0);

    // sticky flags
    check_sticky(1'b0);
    check_sticky(1'b1);

    $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/radio_pkg.sv
hdl/up_axi_lite.sv
rx/radio_rx.sv
tx/radio_tx.sv
tdd/tdd_ctrl.sv
hdl/radio_top.sv
bench/radio_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= radio_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
